// ==== source/lpif_lite_pkg.sv ====
////////////////////
// Flit layout, lane word layout and shared widths of the lite link endpoint
// Compile this package ahead of every other source file
////////////////////
package lpif_lite_pkg;

  ////////////////////
  // Flit fields

  typedef logic [3:0]   state_t;
  typedef logic [1:0]   protid_t;
  typedef logic [127:0] data_t;
  // CRC rides along with the flit and is never checked here
  typedef logic [15:0]  crc_t;

  typedef struct packed {
    state_t  state;
    protid_t protid;
    data_t   data;
    crc_t    crc;
    logic    dvalid;
    logic    valid;
  } flit_t;

  localparam int FLIT_WIDTH = $bits(flit_t);

  ////////////////////
  // Lane word layout

  localparam int LANE_WIDTH   = 40;
  localparam int LANE_PAYLOAD = 38;
  localparam int LANE_STB     = 39;
  localparam int LANE_MRK     = 38;

  typedef logic [LANE_WIDTH-1:0] lane_word_t;

  ////////////////////
  // Control and debug

  typedef logic [7:0]  delay_t;
  typedef logic [31:0] status_t;

endpackage

// ==== source/lpif_lite_user_if.sv ====
////////////////////
// User side of the link. Captures upstream fields into a flit and
// drives received flits onto the downstream fields
////////////////////
module lpif_lite_user_if (
  input  logic                   clk_wr,
  input  logic                   arst_n,

  // Upstream channel
  input  lpif_lite_pkg::state_t  ustrm_state,
  input  lpif_lite_pkg::protid_t ustrm_protid,
  input  lpif_lite_pkg::data_t   ustrm_data,
  input  lpif_lite_pkg::crc_t    ustrm_crc,
  input  logic                   ustrm_dvalid,
  input  logic                   ustrm_valid,

  // From the lane block
  input  lpif_lite_pkg::flit_t   rx_flit,
  input  logic                   align_err,

  // To the lane block
  output lpif_lite_pkg::flit_t   tx_flit,

  // Downstream channel
  output lpif_lite_pkg::state_t  dstrm_state,
  output lpif_lite_pkg::protid_t dstrm_protid,
  output lpif_lite_pkg::data_t   dstrm_data,
  output lpif_lite_pkg::crc_t    dstrm_crc,
  output logic                   dstrm_dvalid,
  output logic                   dstrm_valid,

  output lpif_lite_pkg::status_t rx_downstream_debug_status
);
  import lpif_lite_pkg::*;

  localparam int HALF_WIDTH = $bits(status_t) / 2;

  logic [HALF_WIDTH-1:0] err_cnt_q;
  logic [HALF_WIDTH-1:0] vld_cnt_q;

  ////////////////////
  // Upstream capture

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_flit <= '0;
    end else begin
      tx_flit.state  <= ustrm_state;
      tx_flit.protid <= ustrm_protid;
      tx_flit.data   <= ustrm_data;
      tx_flit.crc    <= ustrm_crc;
      // Data valid only means something on a valid flit
      tx_flit.dvalid <= ustrm_valid & ustrm_dvalid;
      tx_flit.valid  <= ustrm_valid;
    end
  end

  ////////////////////
  // Downstream delivery

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      dstrm_valid  <= 1'b0;
      dstrm_dvalid <= 1'b0;
    end else begin
      dstrm_valid  <= rx_flit.valid;
      dstrm_dvalid <= rx_flit.dvalid;
    end
  end

  always_ff @(posedge clk_wr) begin
    dstrm_state  <= rx_flit.state;
    dstrm_protid <= rx_flit.protid;
    dstrm_data   <= rx_flit.data;
    dstrm_crc    <= rx_flit.crc;
  end

  ////////////////////
  // Receive debug counters

  // Both halves stick at all ones
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      err_cnt_q <= '0;
      vld_cnt_q <= '0;
    end else begin
      if (align_err && (err_cnt_q != '1)) begin
        err_cnt_q <= err_cnt_q + 1'b1;
      end
      // Counted as the flit moves onto dstrm
      if (rx_flit.valid && (vld_cnt_q != '1)) begin
        vld_cnt_q <= vld_cnt_q + 1'b1;
      end
    end
  end

  assign rx_downstream_debug_status = {err_cnt_q, vld_cnt_q};

  // Holds over the whole path from upstream capture through the lanes
  a_dvalid_needs_valid: assert property (
    @(posedge clk_wr) disable iff (!arst_n)
      dstrm_dvalid |-> dstrm_valid
  ) else $error("dstrm_dvalid high while dstrm_valid is low");

endmodule

// ==== source/lpif_lite_auto_sync.sv ====
////////////////////
// Online delay for both directions plus transmit strobe and marker bits
////////////////////
module lpif_lite_auto_sync (
  input  logic                  clk_wr,
  input  logic                  arst_n,
  input  logic                  tx_online,
  input  logic                  rx_online,
  input  lpif_lite_pkg::delay_t delay_x_value,
  input  lpif_lite_pkg::delay_t delay_xz_value,
  output logic                  tx_online_delay,
  output logic                  rx_online_delay,
  output logic                  tx_stb_bit,
  output logic                  tx_mrk_bit
);
  import lpif_lite_pkg::*;

  typedef enum logic [1:0] {
    SYNC_OFFLINE,
    SYNC_COUNT,
    SYNC_ONLINE
  } sync_state_e;

  // Channel 0 is transmit and channel 1 is receive
  logic   [1:0] online_req;
  delay_t [1:0] delay_val;
  logic   [1:0] online_ack;

  assign online_req = {rx_online, tx_online};
  assign delay_val  = {delay_x_value, delay_xz_value};

  ////////////////////
  // Delay state machines

  for (genvar ch = 0; ch < 2; ch++) begin : g_sync
    sync_state_e state_q;
    delay_t      cnt_q;
    delay_t      cnt_inc;

    assign cnt_inc = cnt_q + delay_t'(1);

    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        state_q <= SYNC_OFFLINE;
        cnt_q   <= '0;
      end else if (!online_req[ch]) begin
        state_q <= SYNC_OFFLINE;
        cnt_q   <= '0;
      end else begin
        case (state_q)
          SYNC_OFFLINE: begin
            cnt_q <= delay_t'(1);
            // Delay of one goes straight online on the first high sample
            if (delay_val[ch] <= delay_t'(1)) begin
              state_q <= SYNC_ONLINE;
            end else begin
              state_q <= SYNC_COUNT;
            end
          end
          SYNC_COUNT: begin
            cnt_q <= cnt_inc;
            if (cnt_inc >= delay_val[ch]) begin
              state_q <= SYNC_ONLINE;
            end
          end
          default: begin
            state_q <= SYNC_ONLINE;
          end
        endcase
      end
    end

    assign online_ack[ch] = (state_q == SYNC_ONLINE);
  end

  assign tx_online_delay = online_ack[0];
  assign rx_online_delay = online_ack[1];

  ////////////////////
  // Strobe and marker

  // Strobe is on for every word while transmit is online
  assign tx_stb_bit = tx_online_delay;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_mrk_bit <= 1'b0;
    end else if (tx_online_delay) begin
      tx_mrk_bit <= ~tx_mrk_bit;
    end else begin
      tx_mrk_bit <= 1'b0;
    end
  end

  a_tx_delay_after_online: assert property (
    @(posedge clk_wr) disable iff (!arst_n)
      tx_online_delay |-> $past(tx_online)
  ) else $error("tx_online_delay high without tx_online at the previous edge");

endmodule

// ==== source/lpif_lite_lane_concat.sv ====
////////////////////
// Lane side of the link. Stripes flits over the PHY lanes and
// checks strobe and marker alignment on the way back
////////////////////
module lpif_lite_lane_concat #(
  parameter int NUM_LANES = 4
) (
  input  logic                                      clk_wr,
  input  logic                                      arst_n,

  // Transmit
  input  lpif_lite_pkg::flit_t                      tx_flit,
  output lpif_lite_pkg::lane_word_t [NUM_LANES-1:0] tx_phy,

  // Receive
  input  lpif_lite_pkg::lane_word_t [NUM_LANES-1:0] rx_phy,
  output lpif_lite_pkg::flit_t                      rx_flit,
  output logic                                      align_err,

  // From auto sync
  input  logic                                      tx_online_delay,
  input  logic                                      rx_online_delay,
  input  logic                                      tx_stb_bit,
  input  logic                                      tx_mrk_bit,

  output lpif_lite_pkg::status_t                    tx_upstream_debug_status
);
  import lpif_lite_pkg::*;

  localparam int STRIPE_WIDTH = NUM_LANES * LANE_PAYLOAD;

  if (STRIPE_WIDTH < FLIT_WIDTH) begin : g_lane_check
    $error("lpif_lite_lane_concat needs NUM_LANES of 4 or more, got %0d", NUM_LANES);
  end

  logic [STRIPE_WIDTH-1:0]    tx_stripe;
  logic [STRIPE_WIDTH-1:0]    rx_stripe;
  lane_word_t [NUM_LANES-1:0] tx_lanes;
  logic [NUM_LANES-1:0]       rx_stb;
  logic [NUM_LANES-1:0]       rx_mrk;
  logic                       rx_aligned;
  logic                       rx_locked_q;
  logic                       rx_last_mrk_q;
  status_t                    tx_cnt_q;

  ////////////////////
  // Transmit striping

  always_comb begin
    tx_stripe = '0;
    tx_stripe[FLIT_WIDTH-1:0] = tx_flit;
    for (int k = 0; k < NUM_LANES; k++) begin
      tx_lanes[k]                   = '0;
      tx_lanes[k][LANE_PAYLOAD-1:0] = tx_stripe[k*LANE_PAYLOAD +: LANE_PAYLOAD];
      tx_lanes[k][LANE_STB]         = tx_stb_bit;
      tx_lanes[k][LANE_MRK]         = tx_mrk_bit;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy <= '0;
    end else if (tx_online_delay) begin
      tx_phy <= tx_lanes;
    end else begin
      tx_phy <= '0;
    end
  end

  // Sent valid flits, saturating
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_cnt_q <= '0;
    end else if (tx_online_delay && tx_flit.valid && (tx_cnt_q != '1)) begin
      tx_cnt_q <= tx_cnt_q + 1'b1;
    end
  end

  assign tx_upstream_debug_status = tx_cnt_q;

  ////////////////////
  // Receive alignment

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      rx_stb[k] = rx_phy[k][LANE_STB];
      rx_mrk[k] = rx_phy[k][LANE_MRK];
      rx_stripe[k*LANE_PAYLOAD +: LANE_PAYLOAD] = rx_phy[k][LANE_PAYLOAD-1:0];
    end
  end

  // Unlocked means the first word after going online, either marker is fine
  assign rx_aligned = (&rx_stb)
                   && (rx_mrk == {NUM_LANES{rx_mrk[0]}})
                   && (!rx_locked_q || (rx_mrk[0] != rx_last_mrk_q));

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_flit       <= '0;
      align_err     <= 1'b0;
      rx_locked_q   <= 1'b0;
      rx_last_mrk_q <= 1'b0;
    end else if (!rx_online_delay) begin
      rx_flit     <= '0;
      align_err   <= 1'b0;
      rx_locked_q <= 1'b0;
    end else if (rx_aligned) begin
      rx_flit       <= flit_t'(rx_stripe[FLIT_WIDTH-1:0]);
      align_err     <= 1'b0;
      rx_locked_q   <= 1'b1;
      rx_last_mrk_q <= rx_mrk[0];
    end else begin
      rx_flit       <= '0;
      align_err     <= 1'b1;
      // A dropped word still steps the marker phase
      rx_last_mrk_q <= ~rx_last_mrk_q;
    end
  end

  a_tx_idle_lanes_zero: assert property (
    @(posedge clk_wr) disable iff (!arst_n)
      !tx_online_delay |=> (tx_phy == '0)
  ) else $error("tx_phy not zero after tx_online_delay was low");

endmodule

// ==== source/lpif_lite_top.sv ====
////////////////////
// Top of the lite link endpoint. Ties user side, auto sync and lanes
////////////////////
module lpif_lite_top #(
  parameter int NUM_LANES = 4
) (
  input  logic                                      clk_wr,
  input  logic                                      arst_n,

  // Control
  input  logic                                      tx_online,
  input  logic                                      rx_online,
  input  lpif_lite_pkg::delay_t                     delay_x_value,
  input  lpif_lite_pkg::delay_t                     delay_xz_value,

  // PHY lanes
  output lpif_lite_pkg::lane_word_t [NUM_LANES-1:0] tx_phy,
  input  lpif_lite_pkg::lane_word_t [NUM_LANES-1:0] rx_phy,

  // Upstream channel
  input  lpif_lite_pkg::state_t                     ustrm_state,
  input  lpif_lite_pkg::protid_t                    ustrm_protid,
  input  lpif_lite_pkg::data_t                      ustrm_data,
  input  lpif_lite_pkg::crc_t                       ustrm_crc,
  input  logic                                      ustrm_dvalid,
  input  logic                                      ustrm_valid,

  // Downstream channel
  output lpif_lite_pkg::state_t                     dstrm_state,
  output lpif_lite_pkg::protid_t                    dstrm_protid,
  output lpif_lite_pkg::data_t                      dstrm_data,
  output lpif_lite_pkg::crc_t                       dstrm_crc,
  output logic                                      dstrm_dvalid,
  output logic                                      dstrm_valid,

  // Debug status
  output lpif_lite_pkg::status_t                    rx_downstream_debug_status,
  output lpif_lite_pkg::status_t                    tx_upstream_debug_status
);
  import lpif_lite_pkg::*;

  ////////////////////
  // Interconnect

  flit_t tx_flit;
  flit_t rx_flit;
  logic  align_err;
  logic  tx_online_delay;
  logic  rx_online_delay;
  logic  tx_stb_bit;
  logic  tx_mrk_bit;

  ////////////////////
  // Blocks

  lpif_lite_user_if user_if_inst (
    .clk_wr                     (clk_wr),
    .arst_n                     (arst_n),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_valid                (ustrm_valid),
    .rx_flit                    (rx_flit),
    .align_err                  (align_err),
    .tx_flit                    (tx_flit),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_valid                (dstrm_valid),
    .rx_downstream_debug_status (rx_downstream_debug_status)
  );

  lpif_lite_auto_sync auto_sync_inst (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_bit      (tx_stb_bit),
    .tx_mrk_bit      (tx_mrk_bit)
  );

  lpif_lite_lane_concat #(
    .NUM_LANES (NUM_LANES)
  ) lane_concat_inst (
    .clk_wr                   (clk_wr),
    .arst_n                   (arst_n),
    .tx_flit                  (tx_flit),
    .tx_phy                   (tx_phy),
    .rx_phy                   (rx_phy),
    .rx_flit                  (rx_flit),
    .align_err                (align_err),
    .tx_online_delay          (tx_online_delay),
    .rx_online_delay          (rx_online_delay),
    .tx_stb_bit               (tx_stb_bit),
    .tx_mrk_bit               (tx_mrk_bit),
    .tx_upstream_debug_status (tx_upstream_debug_status)
  );

endmodule

// ==== test/lpif_lite_tb.sv ====
////////////////////
// Testbench for the lite link endpoint with tx to rx loopback and strobe faults
// Reference model tracks the expected lanes, flits and counters cycle by cycle
////////////////////
module lpif_lite_tb;
  import lpif_lite_pkg::*;

  localparam int NUM_LANES    = 4;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 3;
  localparam int TOTAL_CYCLES = RESET_CYCLES + 20 + 30 + 40 + 23 + 20 + 20;

  logic                       clk_wr;
  logic                       arst_n;
  logic                       tx_online;
  logic                       rx_online;
  delay_t                     delay_x_value;
  delay_t                     delay_xz_value;
  lane_word_t [NUM_LANES-1:0] tx_phy;
  lane_word_t [NUM_LANES-1:0] rx_phy;
  state_t                     ustrm_state;
  protid_t                    ustrm_protid;
  data_t                      ustrm_data;
  crc_t                       ustrm_crc;
  logic                       ustrm_dvalid;
  logic                       ustrm_valid;
  state_t                     dstrm_state;
  protid_t                    dstrm_protid;
  data_t                      dstrm_data;
  crc_t                       dstrm_crc;
  logic                       dstrm_dvalid;
  logic                       dstrm_valid;
  status_t                    rx_downstream_debug_status;
  status_t                    tx_upstream_debug_status;

  logic [NUM_LANES-1:0]              stb_fault;
  logic [NUM_LANES-1:0]              phy_stb;
  logic [NUM_LANES-1:0]              phy_mrk;
  logic [NUM_LANES*LANE_PAYLOAD-1:0] phy_stripe;
  flit_t                             dstrm_flit;

  // Reference model state
  int          tx_run;
  int          rx_run;
  logic        exp_tx_on;
  logic        exp_rx_on;
  logic        exp_tx_phy_on;
  logic        word_ok;
  logic        exp_err_pend;
  flit_t       exp_tx_flit;
  flit_t       exp_phy_flit;
  flit_t       exp_rx_flit;
  flit_t       exp_dstrm;
  logic [15:0] exp_err_cnt;
  logic [15:0] exp_vld_cnt;
  status_t     exp_tx_cnt;

  lpif_lite_top #(
    .NUM_LANES (NUM_LANES)
  ) lpif_lite_top_inst (
    .clk_wr                     (clk_wr),
    .arst_n                     (arst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_xz_value             (delay_xz_value),
    .tx_phy                     (tx_phy),
    .rx_phy                     (rx_phy),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_valid                (ustrm_valid),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_valid                (dstrm_valid),
    .rx_downstream_debug_status (rx_downstream_debug_status),
    .tx_upstream_debug_status   (tx_upstream_debug_status)
  );

  initial begin
    clk_wr = 1'b0;
    forever #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
  end

  ////////////////////
  // Loopback with strobe fault mask

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      rx_phy[k] = tx_phy[k];
      if (stb_fault[k]) begin
        rx_phy[k][LANE_STB] = 1'b0;
      end
      phy_stb[k] = tx_phy[k][LANE_STB];
      phy_mrk[k] = tx_phy[k][LANE_MRK];
      // Lane k carries flit bits from k*38 upward
      phy_stripe[k*LANE_PAYLOAD +: LANE_PAYLOAD] = tx_phy[k][LANE_PAYLOAD-1:0];
    end
  end

  assign dstrm_flit = {dstrm_state, dstrm_protid, dstrm_data, dstrm_crc,
                       dstrm_dvalid, dstrm_valid};
  assign word_ok    = exp_tx_phy_on && (stb_fault == '0);

  ////////////////////
  // Reference model

  always @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_run        <= 0;
      rx_run        <= 0;
      exp_tx_on     <= 1'b0;
      exp_rx_on     <= 1'b0;
      exp_tx_phy_on <= 1'b0;
      exp_err_pend  <= 1'b0;
      exp_tx_flit   <= '0;
      exp_phy_flit  <= '0;
      exp_rx_flit   <= '0;
      exp_dstrm     <= '0;
      exp_err_cnt   <= '0;
      exp_vld_cnt   <= '0;
      exp_tx_cnt    <= '0;
    end else begin
      // Online after D consecutive high samples
      tx_run        <= tx_online ? tx_run + 1 : 0;
      rx_run        <= rx_online ? rx_run + 1 : 0;
      exp_tx_on     <= tx_online && (tx_run + 1 >= int'(delay_xz_value));
      exp_rx_on     <= rx_online && (rx_run + 1 >= int'(delay_x_value));
      exp_tx_phy_on <= exp_tx_on;
      exp_tx_flit   <= '{ustrm_state, ustrm_protid, ustrm_data, ustrm_crc,
                         ustrm_dvalid, ustrm_valid};
      exp_phy_flit  <= exp_tx_on ? exp_tx_flit : '0;
      exp_rx_flit   <= (exp_rx_on && word_ok) ? exp_phy_flit : '0;
      exp_err_pend  <= exp_rx_on && !word_ok;
      exp_err_cnt   <= exp_err_cnt + 16'(exp_err_pend);
      exp_dstrm     <= exp_rx_flit;
      exp_vld_cnt   <= exp_vld_cnt + 16'(exp_rx_flit.valid);
      if (exp_tx_on && exp_tx_flit.valid) begin
        exp_tx_cnt <= exp_tx_cnt + 32'd1;
      end
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  ////////////////////
  // Checks

  a_tx_idle: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !exp_tx_phy_on |-> (tx_phy == '0)
  ) else stop_with_error($sformatf("error at %0t: tx_phy expected 0, got %h",
                                   $time, $sampled(tx_phy)));

  a_tx_lanes: assert property (@(posedge clk_wr) disable iff (!arst_n)
    exp_tx_phy_on |-> ((&phy_stb) && (phy_mrk == {NUM_LANES{phy_mrk[0]}}))
  ) else stop_with_error($sformatf("error at %0t: tx_phy strobe/marker expected %b/equal, got %b/%b",
                                   $time, {NUM_LANES{1'b1}}, $sampled(phy_stb),
                                   $sampled(phy_mrk)));

  a_tx_payload: assert property (@(posedge clk_wr) disable iff (!arst_n)
    phy_stripe == (NUM_LANES*LANE_PAYLOAD)'(exp_phy_flit)
  ) else stop_with_error($sformatf("error at %0t: tx_phy payload expected %h, got %h",
                                   $time, $sampled(exp_phy_flit), $sampled(phy_stripe)));

  a_mrk_toggle: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (exp_tx_phy_on && $past(exp_tx_phy_on)) |-> (phy_mrk[0] != $past(phy_mrk[0]))
  ) else stop_with_error($sformatf("error at %0t: tx_phy marker expected %b, got %b",
                                   $time, ~$past(phy_mrk[0]), $sampled(phy_mrk[0])));

  a_dstrm_valid: assert property (@(posedge clk_wr) disable iff (!arst_n)
    {dstrm_dvalid, dstrm_valid} == {exp_dstrm.dvalid, exp_dstrm.valid}
  ) else stop_with_error($sformatf("error at %0t: dstrm_dvalid/valid expected %b, got %b",
                                   $time, $sampled({exp_dstrm.dvalid, exp_dstrm.valid}),
                                   $sampled({dstrm_dvalid, dstrm_valid})));

  a_dstrm_flit: assert property (@(posedge clk_wr) disable iff (!arst_n)
    exp_dstrm.valid |-> (dstrm_flit == exp_dstrm)
  ) else stop_with_error($sformatf("error at %0t: dstrm flit expected %h, got %h",
                                   $time, $sampled(exp_dstrm), $sampled(dstrm_flit)));

  a_rx_status: assert property (@(posedge clk_wr) disable iff (!arst_n)
    rx_downstream_debug_status == {exp_err_cnt, exp_vld_cnt}
  ) else stop_with_error($sformatf("error at %0t: rx_downstream_debug_status expected %h, got %h",
                                   $time, $sampled({exp_err_cnt, exp_vld_cnt}),
                                   $sampled(rx_downstream_debug_status)));

  a_tx_status: assert property (@(posedge clk_wr) disable iff (!arst_n)
    tx_upstream_debug_status == exp_tx_cnt
  ) else stop_with_error($sformatf("error at %0t: tx_upstream_debug_status expected %h, got %h",
                                   $time, $sampled(exp_tx_cnt),
                                   $sampled(tx_upstream_debug_status)));

  ////////////////////
  // Stimulus

  task automatic send_cycle(input int vld_pct, input logic [NUM_LANES-1:0] fault);
    @(negedge clk_wr);
    ustrm_state  = state_t'($urandom);
    ustrm_protid = protid_t'($urandom);
    ustrm_data   = {$urandom, $urandom, $urandom, $urandom};
    ustrm_crc    = crc_t'($urandom);
    ustrm_valid  = int'($urandom % 100) < vld_pct;
    ustrm_dvalid = ustrm_valid && ($urandom % 2 == 1);
    stb_fault    = fault;
  endtask

  task automatic run_cycles(input int n, input int vld_pct);
    repeat (n) send_cycle(vld_pct, '0);
  endtask

  initial begin
    logic [NUM_LANES-1:0] fault_lane;

    void'($urandom(32'hb74dcae2));
    arst_n         = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = 8'd3;
    delay_xz_value = 8'd5;
    ustrm_state    = '0;
    ustrm_protid   = '0;
    ustrm_data     = '0;
    ustrm_crc      = '0;
    ustrm_dvalid   = 1'b0;
    ustrm_valid    = 1'b0;
    stb_fault      = '0;
    fault_lane     = '0;
    repeat (RESET_CYCLES) @(negedge clk_wr);
    arst_n = 1'b1;

    // Offline traffic goes nowhere
    run_cycles(20, 80);
    // Transmit only, receive gated
    tx_online = 1'b1;
    run_cycles(30, 80);
    // Full loopback
    rx_online = 1'b1;
    run_cycles(40, 70);

    // One lane loses its strobe for a single word
    fault_lane[$urandom % NUM_LANES] = 1'b1;
    run_cycles(2, 100);
    send_cycle(100, fault_lane);
    run_cycles(20, 100);

    // Receive off before transmit so idle lanes raise no alignment errors
    rx_online = 1'b0;
    run_cycles(10, 80);
    tx_online = 1'b0;
    run_cycles(10, 80);

    // Shortest delay
    delay_xz_value = 8'd1;
    tx_online      = 1'b1;
    run_cycles(10, 80);
    tx_online = 1'b0;
    run_cycles(10, 80);

    if ((exp_err_cnt != 16'd1) || (exp_vld_cnt == '0) || (exp_tx_cnt == '0)) begin
      stop_with_error("stimulus did not produce exactly one alignment error and delivered flits");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  initial begin
    #((TOTAL_CYCLES + 200) * CLK_PERIOD);
    stop_with_error("timeout: the test sequence did not finish in time");
  end

endmodule

// ==== list.f ====
source/lpif_lite_pkg.sv
source/lpif_lite_user_if.sv
source/lpif_lite_auto_sync.sv
source/lpif_lite_lane_concat.sv
source/lpif_lite_top.sv
test/lpif_lite_tb.sv
